/* Bender.yml */
package:
  name: gemm_sched

sources:
  - include_dirs:
      - logic
    files:
      - logic/gemm_sched_pkg.sv
      - logic/bank_fifo.sv
      - logic/bank_arbiter.sv
      - logic/psum_feeder.sv
      - logic/weight_input_feeder.sv
      - logic/gemm_sched.sv

  - target: test
    include_dirs:
      - logic
    files:
      - test/gemm_sched_tb.sv

/* logic/bank_arbiter.sv */
`timescale 1ns/1ps
`include "gemm_sched_params.svh"

module bank_arbiter (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [`GS_BANKS-1:0]           eligible,
    output logic [$clog2(`GS_BANKS)-1:0]   grant,
    output logic [$clog2(`GS_ROWS)-1:0]    row,
    output logic                           busy,
    output logic                           last,
    output logic [`GS_BANKS-1:0]           bank_rd
);

    localparam int BANK_W = $clog2(`GS_BANKS);
    localparam int ROW_W = $clog2(`GS_ROWS);

    gemm_sched_pkg::arb_state_e state;
    gemm_sched_pkg::arb_state_e next_state;

    // bank under test in check, bank being drained in burst
    logic [BANK_W-1:0] ptr;
    logic [BANK_W-1:0] next_ptr;

    // row of the current burst
    logic [ROW_W-1:0] row_q;
    logic [ROW_W-1:0] next_row;

    // ----------------------------------------
    // state registers
    // ----------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= gemm_sched_pkg::ARB_CHECK;
            ptr <= '0;
            row_q <= '0;
        end
        else begin
            state <= next_state;
            ptr <= next_ptr;
            row_q <= next_row;
        end
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------

    always_comb begin
        next_state = state;
        next_ptr = ptr;
        next_row = row_q;
        case (state)
            gemm_sched_pkg::ARB_CHECK: begin
                // one bank per cycle, round robin
                next_row = '0;
                if (eligible[ptr]) begin
                    next_state = gemm_sched_pkg::ARB_BURST;
                end
                else begin
                    next_ptr = ptr + 1'b1;
                end
            end
            gemm_sched_pkg::ARB_BURST: begin
                next_row = row_q + 1'b1;
                // after the last row resume checking at the following bank
                if (last) begin
                    next_state = gemm_sched_pkg::ARB_CHECK;
                    next_ptr = ptr + 1'b1;
                end
            end
        endcase
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    assign busy = (state == gemm_sched_pkg::ARB_BURST);
    assign last = busy && (row_q == ROW_W'(`GS_ROWS - 1));
    assign grant = ptr;
    assign row = row_q;

    // one pop per burst cycle from the granted bank
    assign bank_rd = busy ? (`GS_BANKS'(1) << ptr) : '0;

    // a burst is exactly GS_ROWS cycles, then at least one check
    a_burst_len: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(busy) |-> busy [*`GS_ROWS] ##1 !busy);

    a_rd_onehot: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(bank_rd));

endmodule

/* logic/bank_fifo.sv */
`timescale 1ns/1ps
`include "gemm_sched_params.svh"

module bank_fifo (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   push,
    input  gemm_sched_pkg::bank_entry_t            entry,
    input  logic                                   pop,
    output gemm_sched_pkg::bank_entry_t            head,
    output logic [$clog2(`GS_FIFO_DEPTH + 1)-1:0]  count,
    output logic                                   empty,
    output logic                                   full
);

    localparam int PTR_W = $clog2(`GS_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`GS_FIFO_DEPTH + 1);

    gemm_sched_pkg::bank_entry_t mem [`GS_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    // pushes at full and pops at empty are dropped here
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(`GS_FIFO_DEPTH));

    // show-ahead, head is the oldest entry whenever not empty
    assign head = mem[rd_ptr];

    // storage only
    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= entry;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // feeders only burst from a bank holding a full burst
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST) pop |-> !empty);

    a_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
        count <= CNT_W'(`GS_FIFO_DEPTH));

endmodule

/* logic/gemm_sched.sv */
`timescale 1ns/1ps
`include "gemm_sched_params.svh"

module gemm_sched (
    input  logic                           CLK,
    input  logic                           nRST,
    // host push port
    input  logic                           push,
    input  logic [$clog2(`GS_BANKS)-1:0]   push_bank,
    input  gemm_sched_pkg::bank_entry_t    push_entry,
    output logic [`GS_BANKS-1:0]           full,
    // array side
    input  logic                           drained,
    input  logic                           new_weight,
    output gemm_sched_pkg::row_beat_t      wi_beat,
    output gemm_sched_pkg::row_beat_t      ps_beat,
    output logic                           wi_mode_weight
);

    localparam int BANK_W = $clog2(`GS_BANKS);
    localparam int CNT_W = $clog2(`GS_FIFO_DEPTH + 1);

    gemm_sched_pkg::bank_entry_t fifo_head [`GS_BANKS];
    gemm_sched_pkg::bank_entry_t heads [`GS_BANKS];
    logic [CNT_W-1:0] counts [`GS_BANKS];
    logic [`GS_BANKS-1:0] empty;
    logic [`GS_BANKS-1:0] pop;

    // per feeder read vectors and busy banks
    logic [`GS_BANKS-1:0] ps_rd;
    logic [`GS_BANKS-1:0] wi_rd;
    logic [`GS_BANKS-1:0] ps_busy;
    logic [`GS_BANKS-1:0] wi_busy;
    logic weight_pending;

    // ----------------------------------------
    // bank FIFOs
    // ----------------------------------------

    for (genvar g = 0; g < `GS_BANKS; g++) begin : g_bank
        bank_fifo fifo_i (
            .CLK   (CLK),
            .nRST  (nRST),
            .push  (push && (push_bank == BANK_W'(g))),
            .entry (push_entry),
            .pop   (pop[g]),
            .head  (fifo_head[g]),
            .count (counts[g]),
            .empty (empty[g]),
            .full  (full[g])
        );

        // an empty bank shows TAG_NONE instead of stale storage
        assign heads[g] = empty[g] ? '0 : fifo_head[g];
    end

    // ----------------------------------------
    // feeders
    // ----------------------------------------

    psum_feeder ps_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .heads          (heads),
        .counts         (counts),
        .other_busy     (wi_busy),
        .weight_pending (weight_pending),
        .beat           (ps_beat),
        .bank_rd        (ps_rd),
        .busy_mask      (ps_busy)
    );

    weight_input_feeder wi_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .heads          (heads),
        .counts         (counts),
        .other_busy     (ps_busy),
        .drained        (drained),
        .new_weight     (new_weight),
        .beat           (wi_beat),
        .mode_weight    (wi_mode_weight),
        .weight_pending (weight_pending),
        .bank_rd        (wi_rd),
        .busy_mask      (wi_busy)
    );

    // masking keeps the two vectors disjoint, so a plain OR is safe
    assign pop = ps_rd | wi_rd;

    a_rd_disjoint: assert property (@(posedge CLK) disable iff (!nRST) (ps_rd & wi_rd) == '0);

endmodule

/* logic/gemm_sched_params.svh */
`ifndef GEMM_SCHED_PARAMS_SVH
`define GEMM_SCHED_PARAMS_SVH

// ----------------------------------------
// scheduler sizing
// ----------------------------------------

// bank FIFOs feeding the array
`define GS_BANKS 4

// rows per burst, one row per cycle
`define GS_ROWS 4

// row payload and tag widths
`define GS_DATA_W 64
`define GS_TAG_W 2

// entries per bank FIFO, power of two
`define GS_FIFO_DEPTH 8

`endif

/* logic/gemm_sched_pkg.sv */
`include "gemm_sched_params.svh"

package gemm_sched_pkg;

    // ----------------------------------------
    // entry format
    // ----------------------------------------

    // tag carried with every row in a bank
    typedef enum logic [`GS_TAG_W-1:0] {
        TAG_NONE   = 2'd0,
        TAG_INPUT  = 2'd1,
        TAG_WEIGHT = 2'd2,
        TAG_PSUM   = 2'd3
    } entry_tag_e;

    // one stored row, tag on top of the data
    typedef struct packed {
        entry_tag_e             tag;
        logic [`GS_DATA_W-1:0]  data;
    } bank_entry_t;

    // ----------------------------------------
    // array side
    // ----------------------------------------

    // one row towards the array
    // data and row only mean something while enable is high
    typedef struct packed {
        logic                          enable;
        logic [$clog2(`GS_ROWS)-1:0]   row;
        logic [`GS_DATA_W-1:0]         data;
    } row_beat_t;

    // burst sequencer states
    typedef enum logic {
        ARB_CHECK = 1'b0,
        ARB_BURST = 1'b1
    } arb_state_e;

endpackage

/* logic/psum_feeder.sv */
`timescale 1ns/1ps
`include "gemm_sched_params.svh"

module psum_feeder (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  gemm_sched_pkg::bank_entry_t            heads [`GS_BANKS],
    input  logic [$clog2(`GS_FIFO_DEPTH + 1)-1:0]  counts [`GS_BANKS],
    input  logic [`GS_BANKS-1:0]                   other_busy,
    input  logic                                   weight_pending,
    output gemm_sched_pkg::row_beat_t              beat,
    output logic [`GS_BANKS-1:0]                   bank_rd,
    output logic [`GS_BANKS-1:0]                   busy_mask
);

    localparam int CNT_W = $clog2(`GS_FIFO_DEPTH + 1);

    logic [`GS_BANKS-1:0] eligible;
    logic [$clog2(`GS_BANKS)-1:0] grant;
    logic [$clog2(`GS_ROWS)-1:0] row;
    logic busy;

    // ----------------------------------------
    // eligibility
    // ----------------------------------------

    // psum head, a whole burst stored, bank free, no weight load pending
    always_comb begin
        for (int b = 0; b < `GS_BANKS; b++) begin
            eligible[b] = (heads[b].tag == gemm_sched_pkg::TAG_PSUM)
                && (counts[b] >= CNT_W'(`GS_ROWS))
                && !other_busy[b]
                && !weight_pending;
        end
    end

    bank_arbiter arb_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .eligible (eligible),
        .grant    (grant),
        .row      (row),
        .busy     (busy),
        .last     (),
        .bank_rd  (bank_rd)
    );

    // ----------------------------------------
    // beat
    // ----------------------------------------

    // head is show-ahead so the popped row is on the bus this cycle
    assign beat.enable = busy;
    assign beat.row = row;
    assign beat.data = heads[grant].data;

    assign busy_mask = bank_rd;

endmodule

/* logic/weight_input_feeder.sv */
`timescale 1ns/1ps
`include "gemm_sched_params.svh"

module weight_input_feeder (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  gemm_sched_pkg::bank_entry_t            heads [`GS_BANKS],
    input  logic [$clog2(`GS_FIFO_DEPTH + 1)-1:0]  counts [`GS_BANKS],
    input  logic [`GS_BANKS-1:0]                   other_busy,
    input  logic                                   drained,
    input  logic                                   new_weight,
    output gemm_sched_pkg::row_beat_t              beat,
    output logic                                   mode_weight,
    output logic                                   weight_pending,
    output logic [`GS_BANKS-1:0]                   bank_rd,
    output logic [`GS_BANKS-1:0]                   busy_mask
);

    localparam int CNT_W = $clog2(`GS_FIFO_DEPTH + 1);

    logic [`GS_BANKS-1:0] eligible;
    logic [$clog2(`GS_BANKS)-1:0] grant;
    logic [$clog2(`GS_ROWS)-1:0] row;
    logic busy;
    logic last;
    logic start;

    // 1 while a weight load is still owed to the array
    logic weight_status;

    // mode of the burst in flight, taken at burst start
    logic mode_q;

    // ----------------------------------------
    // weight status and burst mode
    // ----------------------------------------

    // arbiter leaves check on this edge
    assign start = !busy && eligible[grant];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            weight_status <= 1'b1;
            mode_q <= 1'b1;
        end
        else begin
            // new_weight wins over the end of a weight burst
            if (new_weight) begin
                weight_status <= 1'b1;
            end
            else if (last && mode_q) begin
                weight_status <= 1'b0;
            end
            if (start) begin
                mode_q <= weight_status;
            end
        end
    end

    // ----------------------------------------
    // eligibility
    // ----------------------------------------

    // weight rows need a drained array, input rows only need the tag
    always_comb begin
        for (int b = 0; b < `GS_BANKS; b++) begin
            eligible[b] = (weight_status
                    ? ((heads[b].tag == gemm_sched_pkg::TAG_WEIGHT) && drained)
                    : (heads[b].tag == gemm_sched_pkg::TAG_INPUT))
                && (counts[b] >= CNT_W'(`GS_ROWS))
                && !other_busy[b];
        end
    end

    bank_arbiter arb_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .eligible (eligible),
        .grant    (grant),
        .row      (row),
        .busy     (busy),
        .last     (last),
        .bank_rd  (bank_rd)
    );

    // ----------------------------------------
    // beat
    // ----------------------------------------

    assign beat.enable = busy;
    assign beat.row = row;
    assign beat.data = heads[grant].data;

    // latched mode inside a burst, live flag between bursts
    assign mode_weight = busy ? mode_q : weight_status;
    assign weight_pending = weight_status;

    assign busy_mask = bank_rd;

endmodule

/* test/gemm_sched_tb.sv */
`timescale 1ns/1ps
`include "gemm_sched_params.svh"

module gemm_sched_tb;

    localparam int BANK_W = $clog2(`GS_BANKS);
    localparam int TIMEOUT = 200;

    logic CLK;
    logic nRST;
    logic push;
    logic [BANK_W-1:0] push_bank;
    gemm_sched_pkg::bank_entry_t push_entry;
    logic [`GS_BANKS-1:0] full;
    logic drained;
    logic new_weight;
    gemm_sched_pkg::row_beat_t wi_beat;
    gemm_sched_pkg::row_beat_t ps_beat;
    logic wi_mode_weight;

    // expected contents of each bank, oldest first
    gemm_sched_pkg::bank_entry_t model_q [`GS_BANKS][$];

    // model weight status in this cycle and in the one before
    logic pend;
    logic pend_prev;
    logic last_wt;
    logic wi_mode_exp;
    int wi_bank;
    int ps_bank;
    int wi_seen;
    int ps_seen;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    integer seed;

    gemm_sched gemm_sched_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .push           (push),
        .push_bank      (push_bank),
        .push_entry     (push_entry),
        .full           (full),
        .drained        (drained),
        .new_weight     (new_weight),
        .wi_beat        (wi_beat),
        .ps_beat        (ps_beat),
        .wi_mode_weight (wi_mode_weight)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // an entry is stored only if its bank was not full at that edge
    always @(posedge CLK) begin
        if (nRST && push && !full[push_bank]) begin
            model_q[push_bank].push_back(push_entry);
        end
    end

    // stimulus keeps one candidate bank per tag at a time
    function automatic int pick_bank(gemm_sched_pkg::entry_tag_e tag);
        for (int b = 0; b < `GS_BANKS; b++) begin
            if (model_q[b].size() > 0 && model_q[b][0].tag == tag) begin
                return b;
            end
        end
        return -1;
    endfunction

    task automatic check_beat(input string sig, input int bank, input logic [63:0] data);
        if (bank < 0 || model_q[bank].size() == 0) begin
            errors++;
            $display("%0t: %s carried a row that no bank should have sent", $time, sig);
        end
        else begin
            assert (data == model_q[bank][0].data) else begin
                errors++;
                $display("error at %0t: %s.data expected %h got %h",
                    $time, sig, model_q[bank][0].data, data);
            end
            model_q[bank].delete(0);
        end
    endtask

    // outputs are stable at the falling edge, inputs still hold last cycle's values
    always @(negedge CLK) begin
        if (!nRST) begin
            pend = 1'b1;
            pend_prev = 1'b1;
            last_wt = 1'b0;
            wi_mode_exp = 1'b1;
            wi_bank = -1;
            ps_bank = -1;
        end
        else begin
            // new_weight wins over the end of a weight burst
            pend_prev = pend;
            if (new_weight) begin
                pend = 1'b1;
            end
            else if (last_wt) begin
                pend = 1'b0;
            end
            last_wt = 1'b0;
            if (wi_beat.enable) begin
                // mode is the status seen when the burst was granted
                if (wi_beat.row == 0) begin
                    wi_mode_exp = pend_prev;
                    wi_bank = pick_bank(pend_prev ? gemm_sched_pkg::TAG_WEIGHT
                                                  : gemm_sched_pkg::TAG_INPUT);
                end
                assert (wi_mode_weight == wi_mode_exp) else begin
                    errors++;
                    $display("error at %0t: wi_mode_weight expected %b got %b",
                        $time, wi_mode_exp, wi_mode_weight);
                end
                check_beat("wi_beat", wi_bank, wi_beat.data);
                last_wt = (wi_beat.row == 3) && wi_mode_exp;
                wi_seen++;
            end
            if (ps_beat.enable) begin
                if (ps_beat.row == 0) begin
                    assert (!pend_prev) else begin
                        errors++;
                        $display("%0t: partial-sum burst began during a weight load", $time);
                    end
                    ps_bank = pick_bank(gemm_sched_pkg::TAG_PSUM);
                end
                check_beat("ps_beat", ps_bank, ps_beat.data);
                ps_seen++;
            end
        end
    end

    // ----------------------------------------
    // protocol checks
    // ----------------------------------------

    a_wi_burst: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(wi_beat.enable) |-> wi_beat.row == 0
            ##1 (wi_beat.enable && wi_beat.row == 1)
            ##1 (wi_beat.enable && wi_beat.row == 2)
            ##1 (wi_beat.enable && wi_beat.row == 3) ##1 !wi_beat.enable)
        else begin
            errors++;
            $display("%0t: wi burst did not carry rows 0 to 3 in consecutive cycles", $time);
        end

    a_ps_burst: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(ps_beat.enable) |-> ps_beat.row == 0
            ##1 (ps_beat.enable && ps_beat.row == 1)
            ##1 (ps_beat.enable && ps_beat.row == 2)
            ##1 (ps_beat.enable && ps_beat.row == 3) ##1 !ps_beat.enable)
        else begin
            errors++;
            $display("%0t: ps burst did not carry rows 0 to 3 in consecutive cycles", $time);
        end

    // weight grant happens the cycle before row 0
    a_weight_drained: assert property (@(posedge CLK) disable iff (!nRST)
        (wi_beat.enable && wi_beat.row == 0 && wi_mode_weight) |-> $past(drained))
        else begin
            errors++;
            $display("%0t: weight burst started while the array was not drained", $time);
        end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------

    task automatic push_one(input int bank, input gemm_sched_pkg::entry_tag_e tag);
        @(negedge CLK);
        push <= 1'b1;
        push_bank <= BANK_W'(bank);
        push_entry.tag <= tag;
        push_entry.data <= {$random(seed), $random(seed)};
    endtask

    task automatic end_push();
        @(negedge CLK);
        push <= 1'b0;
    endtask

    task automatic push_rows(input int bank, input gemm_sched_pkg::entry_tag_e tag, input int n);
        for (int i = 0; i < n; i++) begin
            push_one(bank, tag);
        end
        end_push();
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge CLK);
    endtask

    task automatic pulse_new_weight();
        @(negedge CLK);
        new_weight <= 1'b1;
        @(negedge CLK);
        new_weight <= 1'b0;
    endtask

    // ps selects the partial-sum counter, else the wi counter
    task automatic wait_seen(input bit ps, input int target, input string what);
        int cycles;
        cycles = 0;
        while (((ps ? ps_seen : wi_seen) < target) && cycles < TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if ((ps ? ps_seen : wi_seen) < target) begin
            errors++;
            $display("timeout at %0t: %s did not finish within %0d cycles", $time, what, TIMEOUT);
        end
    endtask

    task automatic check_model_empty();
        for (int b = 0; b < `GS_BANKS; b++) begin
            assert (model_q[b].size() == 0) else begin
                errors++;
                $display("bank %0d still holds %0d rows that never streamed",
                    b, model_q[b].size());
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end
        else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    initial begin
        seed = 32'h5d4d91fa;
        nRST = 1'b0;
        push = 1'b0;
        push_bank = '0;
        push_entry = '0;
        drained = 1'b0;
        new_weight = 1'b0;
        wi_seen = 0;
        ps_seen = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST <= 1'b1;

        // quiet after reset, psum rows held behind the pending weight load
        @(negedge CLK);
        assert (full == '0) else begin
            errors++;
            $display("error at %0t: full expected %h got %h", $time, 4'h0, full);
        end
        assert (!wi_beat.enable && !ps_beat.enable) else begin
            errors++;
            $display("error at %0t: beat enables expected 00 got %b%b",
                $time, wi_beat.enable, ps_beat.enable);
        end
        push_rows(0, gemm_sched_pkg::TAG_PSUM, 4);
        idle(16);
        assert (ps_seen == 0) else begin
            errors++;
            $display("%0t: partial sums streamed before any weight load", $time);
        end
        finish_test("reset and psum hold");

        // weight load waits for drained
        push_rows(2, gemm_sched_pkg::TAG_WEIGHT, 4);
        idle(12);
        assert (wi_seen == 0) else begin
            errors++;
            $display("%0t: weight rows streamed before drained rose", $time);
        end
        @(negedge CLK);
        drained <= 1'b1;
        wait_seen(0, 4, "weight burst");
        finish_test("weight load gated by drained");

        // inputs follow, held psums are released
        push_rows(1, gemm_sched_pkg::TAG_INPUT, 4);
        wait_seen(0, 8, "input burst");
        wait_seen(1, 4, "held partial-sum burst");
        idle(4);
        check_model_empty();
        finish_test("input stream and psum release");

        // interleaved pushes, both channels may run together
        for (int i = 0; i < 8; i++) begin
            push_one(3, gemm_sched_pkg::TAG_INPUT);
            push_one(0, gemm_sched_pkg::TAG_PSUM);
        end
        end_push();
        wait_seen(0, 16, "interleaved input bursts");
        wait_seen(1, 12, "interleaved partial-sum bursts");
        idle(4);
        check_model_empty();
        finish_test("two banks in parallel");

        // new_weight blocks inputs and psums until the next weight load
        pulse_new_weight();
        push_rows(1, gemm_sched_pkg::TAG_INPUT, 4);
        push_rows(0, gemm_sched_pkg::TAG_PSUM, 4);
        idle(16);
        assert (wi_seen == 16 && ps_seen == 12) else begin
            errors++;
            $display("%0t: rows streamed while a new weight load was pending", $time);
        end
        push_rows(2, gemm_sched_pkg::TAG_WEIGHT, 4);
        wait_seen(0, 24, "reload and input bursts");
        wait_seen(1, 16, "partial-sum burst after reload");
        idle(4);
        check_model_empty();
        finish_test("new weight hold");

        // fill one bank, the extra push must vanish
        pulse_new_weight();
        push_rows(1, gemm_sched_pkg::TAG_INPUT, `GS_FIFO_DEPTH);
        assert (full[1] == 1'b1) else begin
            errors++;
            $display("error at %0t: full[1] expected %b got %b", $time, 1'b1, full[1]);
        end
        push_rows(1, gemm_sched_pkg::TAG_INPUT, 1);
        push_rows(2, gemm_sched_pkg::TAG_WEIGHT, 4);
        wait_seen(0, 36, "weight load and full bank drain");
        idle(8);
        assert (full == '0) else begin
            errors++;
            $display("error at %0t: full expected %h got %h", $time, 4'h0, full);
        end
        // a stored drop would surface ahead of these rows
        push_rows(1, gemm_sched_pkg::TAG_INPUT, 4);
        wait_seen(0, 40, "input burst after drop");
        idle(4);
        check_model_empty();
        finish_test("full bank and dropped push");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/gemm_sched_pkg.sv
logic/bank_fifo.sv
logic/bank_arbiter.sv
logic/psum_feeder.sv
logic/weight_input_feeder.sv
logic/gemm_sched.sv
test/gemm_sched_tb.sv
